//--- Makefile
VERILATOR ?= verilator
VFLAGS ?= --timing --assert
TOP ?= tb_spi_memory
FILELIST ?= compile.f
OBJ_DIR ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- compile.f
+incdir+tests
hw/spi_mem_pkg.sv
hw/input_conditioner.sv
hw/shift_register.sv
hw/spi_fsm.sv
hw/data_memory.sv
hw/spi_memory.sv
tests/tb_spi_memory.sv

//--- hw/data_memory.sv
// ====================================================================
// 128 x 8 register array, whole array cleared by reset
// read data follows the latched address without a clock
// ====================================================================
`timescale 1ns/10ps
`default_nettype none

module data_memory (
	input wire logic sclk,
	input wire logic arst_n,
	input wire logic addr_we,
	input wire logic [spi_mem_pkg::addr_width-1:0] addr_in,
	input wire logic dm_we,
	input wire logic [spi_mem_pkg::data_width-1:0] write_data,
	output logic [spi_mem_pkg::data_width-1:0] read_data
);

	localparam int depth = 2 ** spi_mem_pkg::addr_width;

	logic [spi_mem_pkg::addr_width-1:0] addr_q;
	logic [spi_mem_pkg::data_width-1:0] mem [depth];

	// address latch
	always_ff @(posedge sclk or negedge arst_n) begin
		if (!arst_n)
			addr_q <= '0;
		else if (addr_we)
			addr_q <= addr_in;
	end

	always_ff @(posedge sclk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < depth; i++)
				mem[i] <= '0;
		end else if (dm_we) begin
			mem[addr_q] <= write_data;
		end
	end

	assign read_data = mem[addr_q];

endmodule

`default_nettype wire

//--- hw/input_conditioner.sv
// ====================================================================
// pin to level latency is 2 + debounce_cycles + 1 sclk cycles
// debounce_cycles must be 1 or more
// ====================================================================
`timescale 1ns/10ps
`default_nettype none

module input_conditioner #(
	parameter int debounce_cycles = 2,
	parameter logic reset_level = 1'b0
) (
	input wire logic sclk,
	input wire logic arst_n,
	input wire logic pin,
	output logic level,
	output logic rise,
	output logic fall
);

	localparam int cnt_w = $clog2(debounce_cycles + 1);

	logic sync_0;
	logic sync_1;
	logic [cnt_w-1:0] stable_cnt;
	logic accept;

	// two flop synchronizer
	always_ff @(posedge sclk or negedge arst_n) begin
		if (!arst_n) begin
			sync_0 <= reset_level;
			sync_1 <= reset_level;
		end else begin
			sync_0 <= pin;
			sync_1 <= sync_0;
		end
	end

	// new value held long enough
	assign accept = (sync_1 != level) && (stable_cnt == cnt_w'(debounce_cycles));

	always_ff @(posedge sclk or negedge arst_n) begin
		if (!arst_n) begin
			stable_cnt <= '0;
			level <= reset_level;
			rise <= 1'b0;
			fall <= 1'b0;
		end else begin
			// any bounce back to the accepted level restarts the count
			if (sync_1 == level || accept)
				stable_cnt <= '0;
			else
				stable_cnt <= stable_cnt + 1'b1;
			if (accept)
				level <= sync_1;
			rise <= accept && sync_1;
			fall <= accept && !sync_1;
		end
	end

endmodule

`default_nettype wire

//--- hw/shift_register.sv
// ====================================================================
// load beats both shift directions
// shift in and shift out are not expected in the same cycle
// ====================================================================
`timescale 1ns/10ps
`default_nettype none

module shift_register (
	input wire logic sclk,
	input wire logic arst_n,
	input wire logic shift_in_en,
	input wire logic serial_in,
	input wire logic shift_out_en,
	input wire logic load,
	input wire logic [spi_mem_pkg::data_width-1:0] parallel_in,
	output logic [spi_mem_pkg::data_width-1:0] parallel_out,
	output logic serial_out
);

	logic [spi_mem_pkg::data_width-1:0] sr_q;

	always_ff @(posedge sclk or negedge arst_n) begin
		if (!arst_n) begin
			sr_q <= '0;
		end else if (load) begin
			sr_q <= parallel_in;
		end else if (shift_in_en) begin
			// mosi enters at the lsb, msb first on the wire
			sr_q <= {sr_q[spi_mem_pkg::data_width-2:0], serial_in};
		end else if (shift_out_en) begin
			// zero fill behind the outgoing bit
			sr_q <= {sr_q[spi_mem_pkg::data_width-2:0], 1'b0};
		end
	end

	assign parallel_out = sr_q;

	// msb goes out first
	assign serial_out = sr_q[spi_mem_pkg::data_width-1];

endmodule

`default_nettype wire

//--- hw/spi_fsm.sv
// ====================================================================
// one command byte plus one data byte per frame, no bursts
// a new frame needs cs_n to go high and low again
// ====================================================================
`timescale 1ns/10ps
`default_nettype none

module spi_fsm (
	input wire logic sclk,
	input wire logic arst_n,
	input wire logic cs_n,
	input wire logic spi_rise,
	input wire logic spi_fall,
	input wire logic rw_bit,
	output logic addr_we,
	output logic dm_we,
	output logic sr_we,
	output logic miso_buff
);

	localparam logic [spi_mem_pkg::count_width-1:0] byte_bits =
		spi_mem_pkg::count_width'(spi_mem_pkg::data_width);

	spi_mem_pkg::fsm_state_e state;
	spi_mem_pkg::fsm_state_e next_state;
	spi_mem_pkg::spi_op_e op;
	logic [spi_mem_pkg::count_width-1:0] bit_cnt;
	logic cs_n_q;
	logic frame_start;
	logic byte_done;
	logic counting;

	assign op = spi_mem_pkg::spi_op_e'(rw_bit);

	// falling cs_n, seen against last cycle's level
	assign frame_start = cs_n_q && !cs_n;

	assign byte_done = (bit_cnt == byte_bits);

	assign counting = (state == spi_mem_pkg::st_receive) ||
		(state == spi_mem_pkg::st_write) ||
		(state == spi_mem_pkg::st_read_shift);

	always_comb begin
		next_state = state;
		case (state)
			spi_mem_pkg::st_idle: begin
				if (frame_start)
					next_state = spi_mem_pkg::st_receive;
			end
			spi_mem_pkg::st_receive: begin
				// rw bit is in bit 0 once all eight are in
				if (byte_done) begin
					if (op == spi_mem_pkg::op_read)
						next_state = spi_mem_pkg::st_read_load;
					else
						next_state = spi_mem_pkg::st_write;
				end
			end
			spi_mem_pkg::st_write: begin
				if (byte_done)
					next_state = spi_mem_pkg::st_done;
			end
			spi_mem_pkg::st_read_load: begin
				// hold the load across the fall that closes the command byte,
				// so the first data bit is not shifted away
				if (spi_fall)
					next_state = spi_mem_pkg::st_read_shift;
			end
			spi_mem_pkg::st_read_shift: begin
				if (byte_done)
					next_state = spi_mem_pkg::st_done;
			end
			spi_mem_pkg::st_done: begin
				next_state = spi_mem_pkg::st_idle;
			end
			default: begin
				next_state = spi_mem_pkg::st_idle;
			end
		endcase
		// abort from anywhere
		if (cs_n)
			next_state = spi_mem_pkg::st_idle;
	end

	always_ff @(posedge sclk or negedge arst_n) begin
		if (!arst_n) begin
			state <= spi_mem_pkg::st_idle;
			cs_n_q <= 1'b1;
			bit_cnt <= '0;
		end else begin
			state <= next_state;
			cs_n_q <= cs_n;
			if (next_state != state)
				bit_cnt <= '0;
			else if (counting && spi_rise)
				bit_cnt <= bit_cnt + 1'b1;
		end
	end

	// registered strobes, one cycle behind the state they decode
	always_ff @(posedge sclk or negedge arst_n) begin
		if (!arst_n) begin
			addr_we <= 1'b0;
			dm_we <= 1'b0;
			sr_we <= 1'b0;
			miso_buff <= 1'b0;
		end else begin
			addr_we <= (state == spi_mem_pkg::st_receive) && byte_done && !cs_n;
			dm_we <= (state == spi_mem_pkg::st_write) && byte_done && !cs_n;
			sr_we <= (state == spi_mem_pkg::st_read_load) && !cs_n;
			// enable once the first load has happened
			miso_buff <= ((state == spi_mem_pkg::st_read_load) && sr_we && !cs_n) ||
				((state == spi_mem_pkg::st_read_shift) && !cs_n);
		end
	end

endmodule

`default_nettype wire

//--- hw/spi_mem_pkg.sv
// ====================================================================
// shared widths and enums for the SPI slave memory
// changing addr_width also changes the memory depth (2**addr_width)
// ====================================================================
`default_nettype none

package spi_mem_pkg;

	// memory word and SPI byte width
	parameter int data_width = 8;

	// address field of the command byte, 128 words
	parameter int addr_width = 7;

	// bit counter must reach data_width
	parameter int count_width = 4;

	// frame sequencing states
	typedef enum logic [2:0] {
		st_idle,
		st_receive,
		st_write,
		st_read_load,
		st_read_shift,
		st_done
	} fsm_state_e;

	// last bit of the command byte
	typedef enum logic {
		op_write = 1'b0,
		op_read = 1'b1
	} spi_op_e;

endpackage

`default_nettype wire

//--- hw/spi_memory.sv
// ====================================================================
// SPI mode 0 slave memory, spi_clk must be much slower than sclk
// miso is data only, the pad driver uses miso_oe
// ====================================================================
`timescale 1ns/10ps
`default_nettype none

module spi_memory #(
	parameter int debounce_cycles = 2
) (
	input wire logic sclk,
	input wire logic arst_n,
	input wire logic spi_clk,
	input wire logic cs_n,
	input wire logic mosi,
	output logic miso,
	output logic miso_oe
);

	// pin order 0 spi_clk, 1 cs_n, 2 mosi
	localparam logic [2:0] reset_levels = 3'b010;

	logic [2:0] pins;
	logic [2:0] pin_level;
	logic [2:0] pin_rise;
	logic [2:0] pin_fall;

	logic addr_we;
	logic dm_we;
	logic sr_we;
	logic miso_buff;
	logic shift_in_en;
	logic shift_out_en;
	logic sr_serial_out;
	logic [spi_mem_pkg::data_width-1:0] sr_q;
	logic [spi_mem_pkg::data_width-1:0] mem_rdata;

	assign pins = {mosi, cs_n, spi_clk};

	generate
		for (genvar i = 0; i < 3; i++) begin : g_cond
			input_conditioner #(
				.debounce_cycles(debounce_cycles),
				.reset_level(reset_levels[i])
			) i_cond (
				.sclk(sclk),
				.arst_n(arst_n),
				.pin(pins[i]),
				.level(pin_level[i]),
				.rise(pin_rise[i]),
				.fall(pin_fall[i])
			);
		end
	endgenerate

	// rises shift mosi in, falls shift read data out; never both in one phase
	assign shift_in_en = pin_rise[0] && !miso_buff;
	assign shift_out_en = pin_fall[0] && miso_buff;

	shift_register i_sr (
		.sclk(sclk),
		.arst_n(arst_n),
		.shift_in_en(shift_in_en),
		.serial_in(pin_level[2]),
		.shift_out_en(shift_out_en),
		.load(sr_we),
		.parallel_in(mem_rdata),
		.parallel_out(sr_q),
		.serial_out(sr_serial_out)
	);

	spi_fsm i_fsm (
		.sclk(sclk),
		.arst_n(arst_n),
		.cs_n(pin_level[1]),
		.spi_rise(pin_rise[0]),
		.spi_fall(pin_fall[0]),
		.rw_bit(sr_q[0]),
		.addr_we(addr_we),
		.dm_we(dm_we),
		.sr_we(sr_we),
		.miso_buff(miso_buff)
	);

	// command byte is address in 7:1, rw in 0
	data_memory i_mem (
		.sclk(sclk),
		.arst_n(arst_n),
		.addr_we(addr_we),
		.addr_in(sr_q[spi_mem_pkg::data_width-1:1]),
		.dm_we(dm_we),
		.write_data(sr_q),
		.read_data(mem_rdata)
	);

	assign miso = sr_serial_out && miso_buff;
	assign miso_oe = miso_buff;

endmodule

`default_nettype wire

//--- tests/spi_master_tasks.svh
// ======================================================================
// SPI mode 0 master tasks, included inside the testbench module
// uses the testbench pins, half_period and the failure tasks
// ======================================================================
`ifndef spi_master_tasks_svh
`define spi_master_tasks_svh

	// step n sclk cycles, landing just after the edge
	task automatic clock_cycles(input int n);
		repeat (n) begin
			@(posedge sclk);
			#2;
		end
	endtask

	// msb first, mosi set while spi_clk is low, miso taken before the rise
	task automatic shift_bits(input logic [7:0] tx, input int nbits, input logic oe_exp,
		output logic [7:0] rx);
		rx = '0;
		for (int i = 0; i < nbits; i++) begin
			mosi = tx[7 - i];
			clock_cycles(half_period);
			assert (miso_oe == oe_exp)
				else report_mismatch($sformatf("miso_oe is %b, expected %b on bit %0d",
					miso_oe, oe_exp, 7 - i));
			rx = {rx[6:0], miso};
			spi_clk = 1'b1;
			clock_cycles(half_period);
			spi_clk = 1'b0;
		end
		mosi = 1'b0;
	endtask

	// command byte then one data byte
	task automatic send_frame(input logic [6:0] addr, input logic rw, input logic [7:0] tx,
		output logic [7:0] rx);
		logic [7:0] cmd_rx;
		check_idle();
		cs_n = 1'b0;
		clock_cycles(half_period);
		shift_bits({addr, rw}, 8, 1'b0, cmd_rx);
		assert (cmd_rx == 8'h00)
			else report_mismatch($sformatf("miso active during command, got %02h", cmd_rx));
		shift_bits(tx, 8, rw, rx);
		clock_cycles(half_period);
		cs_n = 1'b1;
		clock_cycles(idle_gap);
		check_idle();
	endtask

	// write frame cut short by cs_n after nbits data bits
	task automatic abort_write(input logic [6:0] addr, input logic [7:0] tx, input int nbits);
		logic [7:0] rx;
		int waited;
		check_idle();
		cs_n = 1'b0;
		clock_cycles(half_period);
		shift_bits({addr, 1'b0}, 8, 1'b0, rx);
		shift_bits(tx, nbits, 1'b0, rx);
		clock_cycles(2);
		cs_n = 1'b1;
		for (waited = 0; waited < oe_timeout && miso_oe !== 1'b0; waited++)
			clock_cycles(1);
		if (miso_oe !== 1'b0)
			stop_on_timeout("timeout: miso_oe stayed high after the aborted frame");
		clock_cycles(idle_gap);
		check_idle();
	endtask

`endif

//--- tests/tb_spi_memory.sv
// ======================================================================
// testbench for spi_memory with debounce_cycles left at 2
// stops at the first failed check
// ======================================================================
`timescale 1ns/10ps
`default_nettype none

module tb_spi_memory;

	// spi_clk half period in sclk cycles
	localparam int half_period = 16;
	localparam int idle_gap = 24;
	localparam int oe_timeout = 200;

	logic sclk;
	logic arst_n;
	logic spi_clk;
	logic cs_n;
	logic mosi;
	logic miso;
	logic miso_oe;

	logic [31:0] lfsr_state;
	logic [7:0] ref_mem [128];

	spi_memory i_dut (
		.sclk(sclk),
		.arst_n(arst_n),
		.spi_clk(spi_clk),
		.cs_n(cs_n),
		.mosi(mosi),
		.miso(miso),
		.miso_oe(miso_oe)
	);

	initial begin
		sclk = 1'b0;
		forever #20 sclk = ~sclk;
	end

	task automatic report_mismatch(input string msg);
		$display("FAIL at %0d ns: %s", $time, msg);
		$display("Errors found");
		$fatal(1, "stopped at the first failed check");
	endtask

	task automatic stop_on_timeout(input string msg);
		$display("%s", msg);
		$display("Errors found");
		$fatal(1, "stopped after a timeout");
	endtask

	// taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw_bits(input int n, output logic [7:0] value);
		value = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			value = {value[6:0], lfsr_state[0]};
		end
	endtask

	task automatic check_idle();
		assert (miso == 1'b0 && miso_oe == 1'b0)
			else report_mismatch($sformatf("idle outputs miso %b miso_oe %b", miso, miso_oe));
	endtask

	`include "spi_master_tasks.svh"

	task automatic write_word(input logic [6:0] addr, input logic [7:0] data);
		logic [7:0] rx;
		send_frame(addr, 1'b0, data, rx);
		ref_mem[addr] = data;
	endtask

	task automatic read_check(input logic [6:0] addr, input logic [7:0] expected);
		logic [7:0] rx;
		send_frame(addr, 1'b1, 8'h00, rx);
		assert (rx == expected)
			else report_mismatch($sformatf("read of %02h gave %02h, expected %02h",
				addr, rx, expected));
	endtask

	initial begin
		logic [7:0] data;
		logic [6:0] addr;
		logic [6:0] addr_list [16];
		arst_n = 1'b0;
		spi_clk = 1'b0;
		cs_n = 1'b1;
		mosi = 1'b0;
		lfsr_state = 32'h98f0;
		for (int i = 0; i < 128; i++)
			ref_mem[i] = '0;

		// outputs stay quiet through reset
		repeat (8) begin
			@(posedge sclk);
			#2;
			check_idle();
		end
		arst_n = 1'b1;
		clock_cycles(idle_gap);
		check_idle();

		// write then read back, then overwrite the same word
		write_word(7'h15, 8'ha5);
		read_check(7'h15, ref_mem[7'h15]);
		write_word(7'h15, 8'h3c);
		read_check(7'h15, ref_mem[7'h15]);

		// never written word reads as zero
		read_check(7'h7f, 8'h00);

		// sixteen words squeezed into 16 addresses so some get overwritten
		for (int i = 0; i < 16; i++) begin
			draw_bits(4, data);
			addr = 7'h40 | {3'b000, data[3:0]};
			addr_list[i] = addr;
			draw_bits(8, data);
			write_word(addr, data);
		end
		for (int i = 0; i < 16; i++)
			read_check(addr_list[i], ref_mem[addr_list[i]]);

		// aborted write must leave the old word
		abort_write(7'h15, 8'hc3, 4);
		read_check(7'h15, ref_mem[7'h15]);
		abort_write(addr_list[0], ~ref_mem[addr_list[0]], 4);
		read_check(addr_list[0], ref_mem[addr_list[0]]);

		$display("No errors");
		$finish;
	end

endmodule

`default_nettype wire
